/* build.f */
rtl/aes_pkg.sv
rtl/aes_alu_regs_pkg.sv
rtl/sub_bytes.sv
rtl/mix_columns.sv
rtl/aes_round_unit.sv
rtl/apb_reg_file.sv
rtl/aes_vector_alu.sv
verification/tb_clock.sv
verification/tb_aes_vector_alu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_aes_vector_alu
FILELIST   := build.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0 -Wno-fatal
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_aes_vector_alu.sv */
module tb_aes_vector_alu
	import aes_pkg::*;
	import aes_alu_regs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ADD       = 200;                        // AddRoundKey pairs
	localparam int N_RAND      = 50;                         // Runs for each other phase
	localparam int N_ITER      = N_ADD + 5 * N_RAND + 4;
	localparam int WATCHDOG_NS = 2 * N_ITER * 14 * 2 * 20;

	logic     clk;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	tb_clock u_tb_clock (.clk (clk), .rst_n (rst_n));

	aes_vector_alu u_aes_vector_alu (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_state(input string name, input aes_state_u got, input aes_state_u exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input aes_row_t got, input aes_row_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_resp(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	////////////////////
	// APB driver
	////////////////////

	task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk); // Mid access cycle
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		check_resp("pready", apb_rsp.pready, 1'b1);
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic write_word(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] unused_rdata;
		logic        slverr;
		apb_transfer(1'b1, addr, data, unused_rdata, slverr);
		check_resp("pslverr on write", slverr, exp_err);
	endtask

	task automatic read_word(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
		logic slverr;
		apb_transfer(1'b0, addr, 32'h0, data, slverr);
		check_resp("pslverr on read", slverr, exp_err);
	endtask

	task automatic write_state(input logic [7:0] base, input aes_state_u st);
		for (int r = 0; r < 4; r++) begin
			write_word(8'(base + 4 * r), st.words[r], 1'b0);
		end
	endtask

	task automatic read_state(input logic [7:0] base, output aes_state_u st);
		logic [31:0] word;
		for (int r = 0; r < 4; r++) begin
			read_word(8'(base + 4 * r), word, 1'b0);
			st.words[r] = word;
		end
	endtask

	task automatic check_readback(input logic [7:0] base, input aes_state_u exp);
		logic [31:0] word;
		for (int r = 0; r < 4; r++) begin
			read_word(8'(base + 4 * r), word, 1'b0);
			check_word($sformatf("readback 0x%h", 8'(base + 4 * r)), word, exp.words[r]);
		end
	endtask

	// Load both operands, issue, then fetch the result
	task automatic run_op(input aes_state_u a, input aes_state_u b, input logic [4:0] op,
		output aes_state_u got);
		write_state(ADDR_SRC_A, a);
		write_state(ADDR_SRC_B, b);
		write_word(ADDR_OP, {27'd0, op}, 1'b0);
		read_state(ADDR_RESULT, got);
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic aes_byte_t gmul(aes_byte_t a, aes_byte_t b);
		aes_byte_t p;
		aes_byte_t x;
		aes_byte_t y;
		p = 8'h00;
		x = a;
		y = b;
		while (y != 8'h00) begin
			if (y[0]) p = p ^ x;
			x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
			y = y >> 1;
		end
		return p;
	endfunction

	function automatic aes_byte_t sbox_of(aes_byte_t b);
		aes_byte_t inv;
		aes_byte_t base;
		aes_byte_t s;
		int        e;
		inv  = 8'h01;
		base = b;
		e    = 254; // Inverse is b^254 and zero maps to zero
		while (e != 0) begin
			if (e % 2 == 1) inv = gmul(inv, base);
			base = gmul(base, base);
			e    = e / 2;
		end
		for (int i = 0; i < 8; i++) begin
			s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8] ^
				inv[(i + 7) % 8];
		end
		return s ^ 8'h63;
	endfunction

	function automatic aes_state_u expected_result(logic [4:0] op, aes_state_u a, aes_state_u b);
		logic [127:0] fa;
		logic [127:0] res;
		aes_byte_t    col [4];
		fa  = a;
		res = '0;
		case (op)
			OP_ADD_ROUND_KEY: res = a ^ b;
			OP_SHIFT_ROWS: begin
				for (int r = 0; r < 4; r++) begin
					for (int c = 0; c < 4; c++) begin
						res[32 * r + 8 * c +: 8] = fa[32 * r + 8 * ((c + r) % 4) +: 8];
					end
				end
			end
			OP_MIX_COLUMNS: begin
				for (int c = 0; c < 4; c++) begin
					for (int r = 0; r < 4; r++) col[r] = fa[32 * r + 8 * c +: 8];
					for (int r = 0; r < 4; r++) begin
						res[32 * r + 8 * c +: 8] = gmul(8'h02, col[r]) ^
							gmul(8'h03, col[(r + 1) % 4]) ^ col[(r + 2) % 4] ^ col[(r + 3) % 4];
					end
				end
			end
			OP_SUB_BYTES: begin
				for (int i = 0; i < 16; i++) res[8 * i +: 8] = sbox_of(fa[8 * i +: 8]);
			end
			default: res = '0; // NOP and undefined codes
		endcase
		return res;
	endfunction

	function automatic aes_state_u rand_state();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	function automatic logic [4:0] undefined_op();
		logic [4:0] op;
		op = 5'($urandom);
		while (op inside {OP_ADD_ROUND_KEY, OP_SHIFT_ROWS, OP_MIX_COLUMNS, OP_SUB_BYTES}) begin
			op = 5'($urandom);
		end
		return op;
	endfunction

	task automatic run_random(input logic [4:0] op, input int count);
		aes_state_u a;
		aes_state_u b;
		aes_state_u got;
		repeat (count) begin
			a = rand_state();
			b = rand_state();
			run_op(a, b, op, got);
			check_state($sformatf("result op %h", op), got, expected_result(op, a, b));
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		aes_state_u  a;
		aes_state_u  b;
		aes_state_u  got;
		aes_state_u  keep;
		logic [31:0] word;
		logic [4:0]  op;
		apb_req = '0;
		void'($urandom(48353));
		wait (rst_n === 1'b1);

		repeat (N_RAND) begin
			a = rand_state();
			b = rand_state();
			write_state(ADDR_SRC_A, a);
			write_state(ADDR_SRC_B, b);
			check_readback(ADDR_SRC_A, a);
			check_readback(ADDR_SRC_B, b);
		end

		run_random(OP_ADD_ROUND_KEY, N_ADD);
		run_random(OP_SHIFT_ROWS, N_RAND);
		run_random(OP_SUB_BYTES, N_RAND);
		run_random(OP_MIX_COLUMNS, N_RAND);

		// Row 0 holds 00 00 01 53 and the other rows are zero
		run_op(128'h53010000, rand_state(), OP_SUB_BYTES, got);
		check_state("result sbox vector", got, 128'h63636363_63636363_63636363_ed7c6363);
		// Every column is db 13 53 45
		a = 128'h45454545_53535353_13131313_dbdbdbdb;
		run_op(a, rand_state(), OP_MIX_COLUMNS, got);
		check_state("result mix vector", got, 128'hbcbcbcbc_a1a1a1a1_4d4d4d4d_8e8e8e8e);

		repeat (N_RAND) begin
			op = ($urandom_range(1, 0) == 1) ? undefined_op() : OP_NOP;
			a  = rand_state();
			run_op(a, rand_state(), op, got);
			check_state($sformatf("result op %h", op), got, '0);
		end

		// Bad accesses must leave every register alone
		a = rand_state();
		b = rand_state();
		run_op(a, b, OP_ADD_ROUND_KEY, keep);
		check_state("result before errors", keep, expected_result(OP_ADD_ROUND_KEY, a, b));
		// Fresh operands with no OP write expose any stray issue in the result
		a = rand_state();
		b = rand_state();
		write_state(ADDR_SRC_A, a);
		write_state(ADDR_SRC_B, b);
		write_word(8'h40, $urandom, 1'b1);
		read_word(8'h24, word, 1'b1);
		write_word(8'h06, $urandom, 1'b1); // Unaligned inside SRC_A
		write_word(ADDR_RESULT, $urandom, 1'b1);
		write_word(8'(ADDR_RESULT + 8'h0c), $urandom, 1'b1);
		check_readback(ADDR_SRC_A, a);
		check_readback(ADDR_SRC_B, b);
		read_word(ADDR_OP, word, 1'b0);
		check_word("op readback", word, {27'd0, OP_ADD_ROUND_KEY});
		read_state(ADDR_RESULT, got);
		check_state("result after errors", got, keep);

		$display("TEST OK");
		$finish;
	end

endmodule

/* verification/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// Held low across the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* rtl/aes_vector_alu.sv */
module aes_vector_alu
	import aes_pkg::*;
	import aes_alu_regs_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	alu_cmd_t   cmd;    // Operands, opcode and issue strobe
	aes_state_u result; // Registered round output

	apb_reg_file u_apb_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.cmd     (cmd),
		.result  (result)
	);

	aes_round_unit u_aes_round_unit (
		.clk    (clk),
		.rst_n  (rst_n),
		.cmd    (cmd),
		.result (result)
	);

endmodule

/* rtl/apb_reg_file.sv */
module apb_reg_file
	import aes_pkg::*;
	import aes_alu_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  apb_req_t   apb_req,
	output apb_rsp_t   apb_rsp,
	output alu_cmd_t   cmd,
	input  aes_state_u result
);

	aes_state_u src_a_q;
	aes_state_u src_b_q;
	alu_op_e    op_q;
	logic       valid_q;

	logic       access;
	logic       aligned;
	logic [1:0] word_idx;
	logic       hit_a;
	logic       hit_b;
	logic       hit_op;
	logic       hit_res;
	logic       err;
	logic       wr_en;
	logic [31:0] rdata;

	////////////////////
	// Address decode
	////////////////////

	assign access   = apb_req.psel && apb_req.penable; // Second cycle of a transfer
	assign aligned  = (apb_req.paddr[1:0] == 2'b00);
	assign word_idx = apb_req.paddr[3:2];

	assign hit_a   = aligned && (apb_req.paddr[7:4] == ADDR_SRC_A[7:4]);
	assign hit_b   = aligned && (apb_req.paddr[7:4] == ADDR_SRC_B[7:4]);
	assign hit_op  = (apb_req.paddr == ADDR_OP);
	assign hit_res = aligned && (apb_req.paddr[7:4] == ADDR_RESULT[7:4]);

	// Unmapped address, or software trying to write the result
	assign err = access && (!(hit_a || hit_b || hit_op || hit_res) ||
		(apb_req.pwrite && hit_res));

	assign wr_en = access && apb_req.pwrite && !err;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			src_a_q <= '0;
			src_b_q <= '0;
			op_q    <= OP_NOP;
			valid_q <= 1'b0;
		end else begin
			if (wr_en && hit_a) begin
				src_a_q.words[word_idx] <= apb_req.pwdata;
			end
			if (wr_en && hit_b) begin
				src_b_q.words[word_idx] <= apb_req.pwdata;
			end
			if (wr_en && hit_op) begin
				op_q <= alu_op_e'(apb_req.pwdata[4:0]); // Undefined codes kept as written
			end
			valid_q <= wr_en && hit_op; // Issue once the opcode has landed
		end
	end

	////////////////////
	// Read path
	////////////////////

	always_comb begin
		rdata = '0;
		if (hit_a) begin
			rdata = src_a_q.words[word_idx];
		end else if (hit_b) begin
			rdata = src_b_q.words[word_idx];
		end else if (hit_op) begin
			rdata = {27'd0, op_q}; // Zero extended
		end else if (hit_res) begin
			rdata = result.words[word_idx];
		end
	end

	assign apb_rsp.prdata  = (access && !apb_req.pwrite && !err) ? rdata : '0;
	assign apb_rsp.pready  = 1'b1; // No wait states
	assign apb_rsp.pslverr = err;

	assign cmd = '{valid: valid_q, op: op_q, src_a: src_a_q, src_b: src_b_q};

	// Master side protocol and the single cycle issue strobe
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		valid_q |=> !valid_q);
	a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> apb_req.psel);

endmodule

/* rtl/aes_round_unit.sv */
module aes_round_unit
	import aes_pkg::*;
	import aes_alu_regs_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  alu_cmd_t   cmd,
	output aes_state_u result
);

	aes_state_u sub_bytes_res;
	aes_state_u mix_columns_res;
	aes_state_u shift_rows_res;
	aes_state_u add_round_key_res;
	aes_state_u sel;

	////////////////////
	// Datapath
	////////////////////

	sub_bytes u_sub_bytes (
		.state_in  (cmd.src_a),
		.state_out (sub_bytes_res)
	);

	mix_columns u_mix_columns (
		.state_in  (cmd.src_a),
		.state_out (mix_columns_res)
	);

	// Row r rotates left by r bytes
	always_comb begin
		shift_rows_res = '0;
		for (int r = 0; r < AES_NB; r++) begin
			for (int c = 0; c < AES_NB; c++) begin
				shift_rows_res.cells[r][c] = cmd.src_a.cells[r][(c + r) % AES_NB];
			end
		end
	end

	always_comb begin
		add_round_key_res = '0;
		for (int r = 0; r < AES_NB; r++) begin
			add_round_key_res.words[r] = cmd.src_a.words[r] ^ cmd.src_b.words[r];
		end
	end

	////////////////////
	// Select and hold
	////////////////////

	always_comb begin
		case (cmd.op)
			OP_ADD_ROUND_KEY: sel = add_round_key_res;
			OP_SHIFT_ROWS:    sel = shift_rows_res;
			OP_MIX_COLUMNS:   sel = mix_columns_res;
			OP_SUB_BYTES:     sel = sub_bytes_res;
			default:          sel = '0; // NOP and unknown codes read back as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (cmd.valid) begin
			result <= sel; // A newer command simply overwrites
		end
	end

	// Operands and opcode must be known when a command issues
	a_cmd_known: assert property (@(posedge clk) disable iff (!rst_n)
		cmd.valid |-> !$isunknown(cmd));

endmodule

/* rtl/mix_columns.sv */
module mix_columns
	import aes_pkg::*;
(
	input  aes_state_u state_in,
	output aes_state_u state_out
);

	// Each column is a polynomial times {03}x^3 + {01}x^2 + {01}x + {02}
	always_comb begin
		aes_byte_t a [AES_NB];
		aes_byte_t dbl [AES_NB];
		state_out = '0;
		for (int c = 0; c < AES_NB; c++) begin
			for (int r = 0; r < AES_NB; r++) begin
				a[r]   = state_in.cells[r][c]; // Column c, top to bottom
				dbl[r] = xtime(a[r]);
			end
			for (int r = 0; r < AES_NB; r++) begin
				// Row of the circulant matrix 2 3 1 1 starting at r
				state_out.cells[r][c] = dbl[r] ^
					dbl[(r + 1) % AES_NB] ^ a[(r + 1) % AES_NB] ^
					a[(r + 2) % AES_NB] ^
					a[(r + 3) % AES_NB];
			end
		end
	end

endmodule

/* rtl/sub_bytes.sv */
module sub_bytes
	import aes_pkg::*;
(
	input  aes_state_u state_in,
	output aes_state_u state_out
);

	////////////////////
	// S-box arithmetic
	////////////////////

	// Inverse as b^254, zero stays zero
	function automatic aes_byte_t gf_inv(aes_byte_t b);
		aes_byte_t acc;
		acc = b;
		for (int i = 0; i < 6; i++) begin
			acc = gf_mul(gf_mul(acc, acc), b); // b^(2^k - 1) up to b^127
		end
		return gf_mul(acc, acc); // Square once more for b^254
	endfunction

	// Rotate left within one byte
	function automatic aes_byte_t rotl8(aes_byte_t b, int n);
		logic [15:0] twice;
		twice = {b, b} << n;
		return twice[15:8];
	endfunction

	function automatic aes_byte_t sbox(aes_byte_t b);
		aes_byte_t inv;
		aes_byte_t aff;
		inv = gf_inv(b);
		// Bit i picks up bits i+4 .. i+7 of the inverse
		aff = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4);
		return aff ^ AES_SBOX_AFFINE;
	endfunction

	////////////////////
	// Byte array
	////////////////////

	always_comb begin
		state_out = '0;
		for (int r = 0; r < AES_NB; r++) begin
			for (int c = 0; c < AES_NB; c++) begin
				state_out.cells[r][c] = sbox(state_in.cells[r][c]); // Independent per byte
			end
		end
	end

endmodule

/* rtl/aes_alu_regs_pkg.sv */
package aes_alu_regs_pkg;

	import aes_pkg::*;

	////////////////////
	// APB3 bus
	////////////////////

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	////////////////////
	// Register map
	////////////////////

	localparam logic [7:0] ADDR_SRC_A  = 8'h00; // Four words, 0x00 to 0x0C
	localparam logic [7:0] ADDR_SRC_B  = 8'h10; // Round key, 0x10 to 0x1C
	localparam logic [7:0] ADDR_OP     = 8'h20; // Writing here starts an operation
	localparam logic [7:0] ADDR_RESULT = 8'h30; // Read only, 0x30 to 0x3C

	// Opcodes kept from the vector ALU encoding
	typedef enum logic [4:0] {
		OP_NOP           = 5'b00000,
		OP_ADD_ROUND_KEY = 5'b10011,
		OP_SHIFT_ROWS    = 5'b10100,
		OP_MIX_COLUMNS   = 5'b10101,
		OP_SUB_BYTES     = 5'b10110
	} alu_op_e;

	typedef struct packed {
		logic       valid; // One cycle per OP write
		alu_op_e    op;
		aes_state_u src_a;
		aes_state_u src_b;
	} alu_cmd_t;

endpackage

/* rtl/aes_pkg.sv */
package aes_pkg;

	////////////////////
	// Field constants
	////////////////////

	localparam int AES_NB = 4;                      // Rows and columns of the state
	localparam logic [7:0] AES_REDUCE_POLY = 8'h1b; // x^8 term folds back to x^4+x^3+x+1
	localparam logic [7:0] AES_SBOX_AFFINE = 8'h63; // Added after the affine matrix

	////////////////////
	// State types
	////////////////////

	typedef logic [7:0] aes_byte_t;

	// Byte c of a row sits at bits 8c+7:8c
	typedef aes_byte_t [AES_NB-1:0] aes_row_t;

	// Row r sits at bits 32r+31:32r in both views
	typedef union packed {
		aes_row_t [AES_NB-1:0]              words; // Bus words, AddRoundKey
		aes_byte_t [AES_NB-1:0][AES_NB-1:0] cells; // [row][col] for byte work
	} aes_state_u;

	////////////////////
	// GF(2^8) helpers
	////////////////////

	// Multiply by x, reduced modulo the AES polynomial
	function automatic aes_byte_t xtime(aes_byte_t a);
		aes_byte_t shifted;
		shifted = {a[6:0], 1'b0};
		if (a[7]) begin
			shifted = shifted ^ AES_REDUCE_POLY;
		end
		return shifted;
	endfunction

	// General product, shift and add over the bits of b
	function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
		aes_byte_t acc;
		aes_byte_t pow;
		acc = '0;
		pow = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				acc = acc ^ pow; // Add a*x^i
			end
			pow = xtime(pow);
		end
		return acc;
	endfunction

endpackage
